//--- rsa_macros.svh
`ifndef RSA_MACROS_SVH
`define RSA_MACROS_SVH

// operand width of N, y, d and the result
`define RSA_W 256

// bit counters must reach 256 itself, hence one bit over log2
`define RSA_CNT_W 9

`endif

//--- rsa_pkg.sv
`default_nettype none

`include "rsa_macros.svh"

package rsa_pkg;

    typedef logic [`RSA_W-1:0] word_t;

    // two spare bits, room for 2t and for s + b + N
    typedef logic [`RSA_W+1:0] wide_t;

    typedef logic [`RSA_CNT_W-1:0] cnt_t;

    // exponent sequencer states
    typedef enum logic [2:0] {
        IDLE,
        PREP,
        LOOP,
        NEXT,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- rsa_mod_product.sv
`timescale 1ns/10ps
`default_nettype none

`include "rsa_macros.svh"

module rsa_mod_product (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_b,
    output rsa_pkg::word_t o_t,
    output logic           o_ready
);
    import rsa_pkg::*;

    localparam logic S_IDLE = 1'b0;
    localparam logic S_PREP = 1'b1;

    logic  state_r;
    logic  state_w;
    logic  ready_r;
    logic  ready_w;
    cnt_t  cnt_r;
    cnt_t  cnt_w;
    word_t t_r;
    word_t t_w;
    wide_t dbl;

    assign o_t     = t_r;
    assign o_ready = ready_r;

    // t < N, so 2t < 2N and a single subtract brings it back below N
    always_comb begin
        dbl = {1'b0, t_r, 1'b0};
        if (dbl >= wide_t'(i_n)) begin
            dbl = dbl - wide_t'(i_n);
        end
    end

    always_comb begin
        state_w = state_r;
        ready_w = ready_r;
        cnt_w   = cnt_r;
        t_w     = t_r;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w = S_PREP;
                    ready_w = 1'b0;
                    cnt_w   = '0;
                    t_w     = i_b;
                end
            end
            S_PREP: begin
                t_w   = dbl[`RSA_W-1:0];
                cnt_w = cnt_r + 1'b1;
                // last of the 256 doublings
                if (cnt_r == cnt_t'(`RSA_W - 1)) begin
                    state_w = S_IDLE;
                    ready_w = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= S_IDLE;
            ready_r <= 1'b0;
            cnt_r   <= '0;
        end else begin
            state_r <= state_w;
            ready_r <= ready_w;
            cnt_r   <= cnt_w;
        end
    end

    always_ff @(posedge i_clk) begin
        t_r <= t_w;
    end

endmodule

`default_nettype wire

//--- rsa_montgomery.sv
`timescale 1ns/10ps
`default_nettype none

`include "rsa_macros.svh"

module rsa_montgomery (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_a,
    input  rsa_pkg::word_t i_b,
    output rsa_pkg::word_t o_p,
    output logic           o_done
);
    import rsa_pkg::*;

    localparam logic S_IDLE = 1'b0;
    localparam logic S_RUN  = 1'b1;

    logic  state_r;
    logic  state_w;
    logic  done_r;
    logic  done_w;
    cnt_t  cnt_r;
    cnt_t  cnt_w;
    wide_t sum_r;
    wide_t sum_w;
    wide_t base;
    wide_t add_b;
    wide_t add_n;
    logic  a_bit;

    assign o_p    = sum_r[`RSA_W-1:0];
    assign o_done = done_r;

    // one bit step; the first step runs on the start edge from a zero sum
    always_comb begin
        base  = (state_r == S_IDLE) ? '0 : sum_r;
        // cnt is zero whenever the unit sits idle
        a_bit = i_a[cnt_r[`RSA_CNT_W-2:0]];
        add_b = a_bit ? base + wide_t'(i_b) : base;
        // make the sum even before halving
        add_n = add_b[0] ? add_b + wide_t'(i_n) : add_b;
    end

    always_comb begin
        state_w = state_r;
        done_w  = 1'b0;
        cnt_w   = cnt_r;
        sum_w   = sum_r;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w = S_RUN;
                    cnt_w   = cnt_t'(1);
                    sum_w   = add_n >> 1;
                end
            end
            S_RUN: begin
                if (cnt_r == cnt_t'(`RSA_W)) begin
                    // sum stays below 2N, one subtract finishes the reduction
                    state_w = S_IDLE;
                    done_w  = 1'b1;
                    cnt_w   = '0;
                    if (sum_r >= wide_t'(i_n)) begin
                        sum_w = sum_r - wide_t'(i_n);
                    end
                end else begin
                    cnt_w = cnt_r + 1'b1;
                    sum_w = add_n >> 1;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= S_IDLE;
            done_r  <= 1'b0;
            cnt_r   <= '0;
        end else begin
            state_r <= state_w;
            done_r  <= done_w;
            cnt_r   <= cnt_w;
        end
    end

    always_ff @(posedge i_clk) begin
        sum_r <= sum_w;
    end

endmodule

`default_nettype wire

//--- rsa_exp_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "rsa_macros.svh"

module rsa_exp_ctrl (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_d,
    input  rsa_pkg::word_t i_t,
    input  logic           i_ready,
    input  rsa_pkg::word_t i_sq,
    input  rsa_pkg::word_t i_mul,
    input  logic           i_mul_done,
    output logic           o_prep_start,
    output logic           o_mul_start,
    output rsa_pkg::word_t o_pow,
    output rsa_pkg::word_t o_acc,
    output logic           o_busy,
    output logic           o_done,
    output rsa_pkg::word_t o_result
);
    import rsa_pkg::*;

    ctrl_state_t state_r;
    ctrl_state_t state_w;
    cnt_t        bit_r;
    cnt_t        bit_w;
    word_t       exp_r;
    word_t       exp_w;
    word_t       pow_r;
    word_t       pow_w;
    word_t       acc_r;
    word_t       acc_w;

    // preprocessor starts on the same edge that accepts i_start,
    // so its ready is already low once we sit in PREP
    assign o_prep_start = (state_r == IDLE) && i_start;

    // both multipliers get one start per exponent bit
    assign o_mul_start = (state_r == NEXT);

    assign o_pow  = pow_r;
    assign o_acc  = acc_r;
    assign o_busy = (state_r != IDLE);
    assign o_done = (state_r == DONE);

    // acc ends as y^d mod N in the plain domain
    assign o_result = acc_r;

    always_comb begin
        state_w = state_r;
        bit_w   = bit_r;
        exp_w   = exp_r;
        pow_w   = pow_r;
        acc_w   = acc_r;
        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_w = PREP;
                    bit_w   = '0;
                    exp_w   = i_d;
                    acc_w   = word_t'(1);
                end
            end
            PREP: begin
                // power register starts as y*R mod N
                if (i_ready) begin
                    pow_w   = i_t;
                    state_w = NEXT;
                end
            end
            NEXT: begin
                state_w = LOOP;
            end
            LOOP: begin
                if (i_mul_done) begin
                    pow_w = i_sq;
                    // multiply in only for a set exponent bit
                    if (exp_r[0]) begin
                        acc_w = i_mul;
                    end
                    exp_w = exp_r >> 1;
                    bit_w = bit_r + 1'b1;
                    if (bit_r == cnt_t'(`RSA_W - 1)) begin
                        state_w = DONE;
                    end else begin
                        state_w = NEXT;
                    end
                end
            end
            DONE: begin
                state_w = IDLE;
            end
            default: begin
                state_w = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= IDLE;
            bit_r   <= '0;
        end else begin
            state_r <= state_w;
            bit_r   <= bit_w;
        end
    end

    // operand registers, held steady while the multipliers run
    always_ff @(posedge i_clk) begin
        exp_r <= exp_w;
        pow_r <= pow_w;
        acc_r <= acc_w;
    end

endmodule

`default_nettype wire

//--- rsa_core.sv
`timescale 1ns/10ps
`default_nettype none

module rsa_core (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_y,
    input  rsa_pkg::word_t i_d,
    output rsa_pkg::word_t o_result,
    output logic           o_busy,
    output logic           o_done
);
    import rsa_pkg::*;

    logic  prep_start;
    logic  prep_ready;
    logic  mul_start;
    logic  mul_done;
    word_t prep_t;
    word_t pow;
    word_t acc;
    word_t sq_p;
    word_t mul_p;

    // y into the Montgomery domain
    rsa_mod_product prep_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start),
        .i_n     (i_n),
        .i_b     (i_y),
        .o_t     (prep_t),
        .o_ready (prep_ready)
    );

    // squares the running power
    rsa_montgomery sq_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_n     (i_n),
        .i_a     (pow),
        .i_b     (pow),
        .o_p     (sq_p),
        .o_done  ()
    );

    // multiplies the power into the accumulator, same start so same done
    rsa_montgomery mul_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_n     (i_n),
        .i_a     (acc),
        .i_b     (pow),
        .o_p     (mul_p),
        .o_done  (mul_done)
    );

    rsa_exp_ctrl ctrl_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_d          (i_d),
        .i_t          (prep_t),
        .i_ready      (prep_ready),
        .i_sq         (sq_p),
        .i_mul        (mul_p),
        .i_mul_done   (mul_done),
        .o_prep_start (prep_start),
        .o_mul_start  (mul_start),
        .o_pow        (pow),
        .o_acc        (acc),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_result     (o_result)
    );

endmodule

`default_nettype wire

//--- tb_rsa_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rsa_core;
    import rsa_pkg::*;

    localparam int TIMEOUT_CYCLES = 80000;

    logic        i_clk;
    logic        i_rst;
    logic        i_start;
    word_t       i_n;
    word_t       i_y;
    word_t       i_d;
    word_t       o_result;
    logic        o_busy;
    logic        o_done;
    int          check_errors;
    int          errors_before;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_val;

    rsa_core dut_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_n      (i_n),
        .i_y      (i_y),
        .i_d      (i_d),
        .o_result (o_result),
        .o_busy   (o_busy),
        .o_done   (o_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // square and multiply on plain integers, reduced after every product
    function automatic word_t model_modexp(input word_t n, input word_t y, input word_t d);
        logic [511:0] m;
        logic [511:0] r;
        logic [511:0] b;
        int           i;
        m = {256'b0, n};
        r = 512'd1;
        b = {256'b0, y} % m;
        for (i = 0; i < 256; i++) begin
            if (d[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[255:0];
    endfunction

    function automatic word_t random_word();
        word_t w;
        int    i;
        for (i = 0; i < 8; i++) begin
            w[i*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    // full width odd modulus
    function automatic word_t random_modulus();
        word_t w;
        w = random_word();
        w[255] = 1'b1;
        w[0] = 1'b1;
        return w;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h",
                     $time, name, got, expected);
            check_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0d ns: %s got %b expected %b",
                     $time, name, got, expected);
            check_errors++;
        end
    endtask

    task automatic check_state(input string name, input ctrl_state_t got,
                               input ctrl_state_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0d ns: %s got %s expected %s",
                     $time, name, got.name(), expected.name());
            check_errors++;
        end
    endtask

    task automatic start_op(input word_t n, input word_t y, input word_t d);
        @(posedge i_clk);
        i_n <= n;
        i_y <= y;
        i_d <= d;
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(negedge i_clk);
        check_bit("o_busy", o_busy, 1'b1);
    endtask

    task automatic wait_done(output logic ok);
        int          cycles;
        ctrl_state_t st;
        cycles = 0;
        while (o_done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge i_clk);
            cycles++;
        end
        ok = (o_done === 1'b1);
        if (!ok) begin
            st = dut_i.ctrl_i.state_r;
            $display("ERROR at %0d ns: o_done never came within %0d cycles, controller in %s",
                     $time, TIMEOUT_CYCLES, st.name());
            check_errors++;
        end
    endtask

    // result, then done as a single pulse and busy dropping after it
    task automatic finish_op(input word_t expected);
        logic ok;
        wait_done(ok);
        if (ok) begin
            check_word("o_result", o_result, expected);
            @(negedge i_clk);
            check_bit("o_busy", o_busy, 1'b0);
            check_bit("o_done", o_done, 1'b0);
        end
    endtask

    task automatic run_and_check(input word_t n, input word_t y, input word_t d,
                                 input word_t expected);
        start_op(n, y, d);
        finish_op(expected);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (check_errors != errors_before) begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, check_errors - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
        errors_before = check_errors;
    endtask

    task automatic test_small_values();
        // 7^13 is 2 mod 11 and 7 mod 13, hence 46
        check_word("model 7^13 mod 143", model_modexp(256'd143, 256'd7, 256'd13), 256'd46);
        run_and_check(256'd143, 256'd7, 256'd13, model_modexp(256'd143, 256'd7, 256'd13));
        report_test("small values");
    endtask

    task automatic test_edge_exponents();
        word_t n;
        word_t y;
        run_and_check(256'd143, 256'd7, 256'd1, 256'd7);
        run_and_check(256'd143, 256'd7, 256'd0, 256'd1);
        n = random_modulus();
        y = random_word() % n;
        run_and_check(n, y, 256'd1, y);
        report_test("edge exponents");
    endtask

    task automatic test_random_cases();
        word_t n;
        word_t y;
        word_t d;
        int    i;
        for (i = 0; i < 5; i++) begin
            n = random_modulus();
            y = random_word() % n;
            d = random_word();
            run_and_check(n, y, d, model_modexp(n, y, d));
        end
        report_test("random 256-bit cases");
    endtask

    task automatic test_start_while_busy();
        word_t n;
        word_t y;
        word_t d;
        n = random_modulus();
        y = random_word() % n;
        d = random_word();
        start_op(n, y, d);
        repeat (300) @(posedge i_clk);
        // N stays, y and d change under a second start
        i_y <= random_word() % n;
        i_d <= random_word();
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(negedge i_clk);
        check_bit("o_busy", o_busy, 1'b1);
        finish_op(model_modexp(n, y, d));
        report_test("start while busy");
    endtask

    task automatic test_reset_mid_op();
        word_t n;
        word_t y;
        word_t d;
        n = random_modulus();
        y = random_word() % n;
        d = random_word();
        start_op(n, y, d);
        repeat (1000) @(posedge i_clk);
        i_rst <= 1'b1;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_done", o_done, 1'b0);
        check_state("ctrl state", dut_i.ctrl_i.state_r, IDLE);
        @(posedge i_clk);
        i_rst <= 1'b0;
        d = random_word();
        run_and_check(n, y, d, model_modexp(n, y, d));
        report_test("reset mid operation");
    endtask

    initial begin
        i_rst = 1'b1;
        i_start = 1'b0;
        i_n = '0;
        i_y = '0;
        i_d = '0;
        check_errors = 0;
        errors_before = 0;
        tests_run = 0;
        tests_failed = 0;
        seed_val = $urandom(32'h92ba);
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        test_small_values();
        test_edge_exponents();
        test_random_cases();
        test_start_while_busy();
        test_reset_mid_op();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, check_errors);
        if (check_errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rsa_core.f
+incdir+.
rsa_pkg.sv
rsa_mod_product.sv
rsa_montgomery.sv
rsa_exp_ctrl.sv
rsa_core.sv
tb_rsa_core.sv

//--- Makefile
TOP = tb_rsa_core

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f rsa_core.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
